//--- list.f
+incdir+hw
+incdir+verification
hw/viaPkg.sv
hw/viaBusDecode.sv
hw/viaEdgeDetect.sv
hw/viaTimers.sv
hw/viaIrqFlags.sv
hw/viaPortRegs.sv
hw/via.sv
verification/viaTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module viaTb -f list.f -o viaSim \
	&& ./obj_dir/viaSim | tee sim.log \
	|| { echo "Build or simulation did not run"; exit 1; }
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

//--- verification/viaTbTable.svh
`ifndef VIA_TB_TABLE_SVH
`define VIA_TB_TABLE_SVH

// Sequencer operations
typedef enum logic [3:0] {
	opWrite,
	opReadExpect,
	opSetPins,
	opWaitIrqLow,
	opWaitIrqHigh,
	opIdle,
	opCheckIrq,
	opCheckPort,
	opEndTest
} tbOpE;

// Columns are op, register, data and expected
// readExpect compares only the bits set in data, and a zero mask only reads
// setPins picks portAIn (regOra), portBIn (regOrb) or {cb2, cb1, ca2, ca1} (regPcr)
// checkPort gives the output enable in data and the enabled output bits in expected
// idle waits data cycles, endTest closes test number data
typedef struct packed {
	tbOpE   op;
	viaRegE regSel;
	logic [7:0] data;
	logic [7:0] expected;
} stepT;

localparam int NumSteps = 76;

localparam stepT Steps [NumSteps] = '{
	// Reset state
	'{opReadExpect, regDdra, 8'hFF, 8'h00},
	'{opReadExpect, regDdrb, 8'hFF, 8'h00},
	'{opReadExpect, regAcr,  8'hFF, 8'h00},
	'{opReadExpect, regIer,  8'hFF, 8'h80},
	'{opReadExpect, regIfr,  8'hFF, 8'h00},
	'{opCheckIrq,   regSr,   8'h00, 8'h01},
	'{opCheckPort,  regOra,  8'h00, 8'h00},
	'{opCheckPort,  regOrb,  8'h00, 8'h00},
	'{opEndTest,    regSr,   8'h00, 8'h00},
	// Port direction
	'{opWrite,      regDdra, 8'h0F, 8'h00},
	'{opWrite,      regOra,  8'hA5, 8'h00},
	'{opCheckPort,  regOra,  8'h0F, 8'h05},
	'{opSetPins,    regOra,  8'h30, 8'h00},
	'{opReadExpect, regOra,  8'hFF, 8'h35},
	'{opWrite,      regDdrb, 8'hF0, 8'h00},
	'{opWrite,      regOrb,  8'h5A, 8'h00},
	'{opCheckPort,  regOrb,  8'hF0, 8'h50},
	'{opSetPins,    regOrb,  8'h0C, 8'h00},
	'{opReadExpect, regOrb,  8'hFF, 8'h5C},
	'{opEndTest,    regSr,   8'h01, 8'h00},
	// Timer 1 one-shot, then no second event
	'{opWrite,      regIer,  8'hC0, 8'h00},
	'{opWrite,      regT1cL, 8'h10, 8'h00},
	'{opWrite,      regT1cH, 8'h00, 8'h00},
	'{opWaitIrqLow, regSr,   8'h00, 8'h00},
	'{opReadExpect, regT1cL, 8'h00, 8'h00},
	'{opWaitIrqHigh, regSr,  8'h00, 8'h00},
	'{opIdle,       regSr,   8'd96, 8'h00},
	'{opCheckIrq,   regSr,   8'h00, 8'h01},
	'{opEndTest,    regSr,   8'h02, 8'h00},
	// Timer 1 free-run with PB7
	'{opWrite,      regDdrb, 8'h80, 8'h00},
	'{opWrite,      regAcr,  8'hC0, 8'h00},
	'{opWrite,      regT1cL, 8'h20, 8'h00},
	'{opWrite,      regT1cH, 8'h00, 8'h00},
	'{opCheckPort,  regOrb,  8'h80, 8'h00},
	'{opWaitIrqLow, regSr,   8'h00, 8'h00},
	'{opCheckPort,  regOrb,  8'h80, 8'h80},
	'{opWrite,      regIfr,  8'h40, 8'h00},
	'{opWaitIrqHigh, regSr,  8'h00, 8'h00},
	'{opWaitIrqLow, regSr,   8'h00, 8'h00},
	'{opCheckPort,  regOrb,  8'h80, 8'h00},
	'{opWrite,      regAcr,  8'h00, 8'h00},
	'{opWrite,      regIer,  8'h40, 8'h00},
	'{opWrite,      regIfr,  8'h7F, 8'h00},
	'{opCheckIrq,   regSr,   8'h00, 8'h01},
	'{opEndTest,    regSr,   8'h03, 8'h00},
	// Control-line edges
	'{opWrite,      regPcr,  8'h01, 8'h00},
	'{opSetPins,    regPcr,  8'h01, 8'h00},
	'{opReadExpect, regIfr,  8'h7F, 8'h02},
	'{opWrite,      regIfr,  8'h02, 8'h00},
	'{opSetPins,    regPcr,  8'h00, 8'h00},
	'{opReadExpect, regIfr,  8'h7F, 8'h00},
	'{opWrite,      regPcr,  8'h00, 8'h00},
	'{opSetPins,    regPcr,  8'h01, 8'h00},
	'{opReadExpect, regIfr,  8'h7F, 8'h00},
	'{opSetPins,    regPcr,  8'h00, 8'h00},
	'{opReadExpect, regIfr,  8'h7F, 8'h02},
	'{opReadExpect, regOra,  8'h00, 8'h00},
	'{opReadExpect, regIfr,  8'h7F, 8'h00},
	'{opWrite,      regPcr,  8'h50, 8'h00},
	'{opSetPins,    regPcr,  8'h0C, 8'h00},
	'{opReadExpect, regIfr,  8'h7F, 8'h18},
	'{opWrite,      regIfr,  8'h18, 8'h00},
	'{opReadExpect, regIfr,  8'h7F, 8'h00},
	'{opEndTest,    regSr,   8'h04, 8'h00},
	// Timer 2 and enable masking
	'{opWrite,      regT2cL, 8'h18, 8'h00},
	'{opWrite,      regT2cH, 8'h00, 8'h00},
	'{opIdle,       regSr,   8'd96, 8'h00},
	'{opCheckIrq,   regSr,   8'h00, 8'h01},
	'{opReadExpect, regIfr,  8'hFF, 8'h20},
	'{opWrite,      regIer,  8'hA0, 8'h00},
	'{opWaitIrqLow, regSr,   8'h00, 8'h00},
	'{opReadExpect, regIfr,  8'hFF, 8'hA0},
	'{opWrite,      regIer,  8'h20, 8'h00},
	'{opWaitIrqHigh, regSr,  8'h00, 8'h00},
	'{opReadExpect, regIer,  8'hFF, 8'h80},
	'{opEndTest,    regSr,   8'h05, 8'h00}
};

`endif

//--- verification/viaTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "via_settings.svh"

module viaTb import viaPkg::*; ();

	`include "viaTbTable.svh"

	localparam int TimeoutCycles = 200;

	logic                   clk;
	logic                   nRESET;
	logic                   clkEn;
	logic                   cs1;
	logic                   nCs2;
	logic                   rnW;
	logic [3:0]             rs;
	logic [`VIA_DATA_W-1:0] dataIn;
	logic [`VIA_DATA_W-1:0] portAIn;
	logic [`VIA_DATA_W-1:0] portBIn;
	logic                   ca1;
	logic                   ca2;
	logic                   cb1;
	logic                   cb2;
	logic [`VIA_DATA_W-1:0] dataOut;
	logic [`VIA_DATA_W-1:0] portAOut;
	logic [`VIA_DATA_W-1:0] portAOe;
	logic [`VIA_DATA_W-1:0] portBOut;
	logic [`VIA_DATA_W-1:0] portBOe;
	logic                   nIrq;

	int    errors;
	int    checks;
	string testNames [6] = '{"reset state", "port direction", "timer 1 one-shot",
		"timer 1 free-run", "control-line edges", "timer 2 and masking"};

	via i_dut (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .cs1(cs1), .nCs2(nCs2),
		.rnW(rnW), .rs(rs), .dataIn(dataIn), .portAIn(portAIn), .portBIn(portBIn),
		.ca1(ca1), .ca2(ca2), .cb1(cb1), .cb2(cb2), .dataOut(dataOut),
		.portAOut(portAOut), .portAOe(portAOe), .portBOut(portBOut),
		.portBOe(portBOe), .nIrq(nIrq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Bus enable high on every second cycle
	initial begin
		clkEn = 1'b0;
		forever begin
			@(posedge clk);
			clkEn <= ~clkEn;
		end
	end

	task automatic compareByte(input string what, input logic [7:0] got,
			input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
			errors++;
		end
	endtask

	// One register access in the next cycle with clkEn high
	task automatic busAccess(input logic write, input viaRegE sel,
			input logic [7:0] wdata, output logic [7:0] rdata);
		logic found;
		found = 1'b0;
		// Old clkEn low here means the coming cycle is enabled
		for (int i = 0; i < 4 && !found; i++) begin
			@(posedge clk);
			found = (clkEn == 1'b0);
		end
		assert (found) else begin
			$display("Bus access at %0t found no enabled cycle", $time);
			errors++;
		end
		cs1 <= 1'b1;
		nCs2 <= 1'b0;
		rnW <= ~write;
		rs <= sel;
		dataIn <= wdata;
		@(negedge clk);
		rdata = dataOut;
		@(posedge clk);
		cs1 <= 1'b0;
		nCs2 <= 1'b1;
		rnW <= 1'b1;
	endtask

	task automatic waitIrq(input logic level);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < TimeoutCycles && !seen; i++) begin
			@(negedge clk);
			seen = (nIrq == level);
		end
		checks++;
		assert (seen) else begin
			$display("Timeout at %0t: the wait for nIrq to go %s did not finish",
				$time, level ? "high" : "low");
			errors++;
		end
	endtask

	task automatic setPins(input viaRegE sel, input logic [7:0] value);
		int gap;
		gap = $urandom % 4;
		repeat (gap + 1) @(posedge clk);
		case (sel)
			regOra: portAIn <= value;
			regOrb: portBIn <= value;
			default: {cb2, cb1, ca2, ca1} <= value[3:0];
		endcase
		// Synchronizer, edge detect and flag update
		repeat (4) @(posedge clk);
	endtask

	initial begin
		stepT       step;
		viaRegE     sel;
		logic [7:0] rdata;
		int         startErrors;
		void'($urandom(32'h8313_04fb));
		nRESET = 1'b0;
		cs1 = 1'b0;
		nCs2 = 1'b1;
		rnW = 1'b1;
		rs = 4'h0;
		dataIn = '0;
		portAIn = '0;
		portBIn = '0;
		{cb2, cb1, ca2, ca1} = 4'h0;
		errors = 0;
		checks = 0;
		startErrors = 0;
		repeat (5) @(posedge clk);
		nRESET <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < NumSteps; i++) begin
			step = Steps[i];
			sel = step.regSel;
			case (step.op)
				opWrite: busAccess(1'b1, sel, step.data, rdata);
				opReadExpect: begin
					busAccess(1'b0, sel, 8'h00, rdata);
					// Reads that only clear flags carry no mask
					if (step.data != 8'h00) begin
						compareByte(sel.name(), rdata & step.data,
							step.expected & step.data);
					end
				end
				opSetPins: setPins(sel, step.data);
				opWaitIrqLow: waitIrq(1'b0);
				opWaitIrqHigh: waitIrq(1'b1);
				opIdle: repeat (step.data) @(posedge clk);
				opCheckIrq: begin
					@(negedge clk);
					compareByte("nIrq", {7'd0, nIrq}, step.expected);
				end
				opCheckPort: begin
					@(negedge clk);
					if (sel == regOra) begin
						compareByte("portAOe", portAOe, step.data);
						compareByte("portAOut", portAOut & portAOe, step.expected);
					end else begin
						compareByte("portBOe", portBOe, step.data);
						compareByte("portBOut", portBOut & portBOe, step.expected);
					end
				end
				opEndTest: begin
					if (errors == startErrors) begin
						$display("Test %0d, %s: ok", step.data, testNames[step.data]);
					end else begin
						$display("Test %0d, %s: %0d errors", step.data,
							testNames[step.data], errors - startErrors);
					end
					startErrors = errors;
				end
				default: ;
			endcase
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/via.sv
`timescale 1ns/1ps
`default_nettype none

`include "via_settings.svh"

module via import viaPkg::*; (
	input  logic                   clk,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  logic                   cs1,
	input  logic                   nCs2,
	input  logic                   rnW,
	input  logic [3:0]             rs,
	input  logic [`VIA_DATA_W-1:0] dataIn,
	input  logic [`VIA_DATA_W-1:0] portAIn,
	input  logic [`VIA_DATA_W-1:0] portBIn,
	input  logic                   ca1,
	input  logic                   ca2,
	input  logic                   cb1,
	input  logic                   cb2,
	output logic [`VIA_DATA_W-1:0] dataOut,
	output logic [`VIA_DATA_W-1:0] portAOut,
	output logic [`VIA_DATA_W-1:0] portAOe,
	output logic [`VIA_DATA_W-1:0] portBOut,
	output logic [`VIA_DATA_W-1:0] portBOe,
	output logic                   nIrq
);

	busReqT                  req;
	viaRegE                  readReg;
	ctrlRegsT                ctrl;
	ctrlEdgeT                edges;
	timerEvT                 timerEv;
	logic [`VIA_TIMER_W-1:0] t1Count;
	logic [`VIA_TIMER_W-1:0] t1Latch;
	logic [`VIA_TIMER_W-1:0] t2Count;
	logic                    pb7;
	logic [`VIA_DATA_W-1:0]  flagByte;
	logic [`VIA_DATA_W-1:0]  enableByte;

	// Input side
	viaBusDecode i_busDecode (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .cs1(cs1), .nCs2(nCs2),
		.rnW(rnW), .rs(rs), .dataIn(dataIn), .req(req), .readReg(readReg)
	);

	viaEdgeDetect i_edgeDetect (
		.clk(clk), .nRESET(nRESET), .ca1(ca1), .ca2(ca2), .cb1(cb1), .cb2(cb2),
		.ctrl(ctrl), .edges(edges)
	);

	// Processing
	viaTimers i_timers (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .req(req), .ctrl(ctrl),
		.ev(timerEv), .t1Count(t1Count), .t1Latch(t1Latch), .t2Count(t2Count),
		.pb7(pb7)
	);

	viaIrqFlags i_irqFlags (
		.clk(clk), .nRESET(nRESET), .req(req), .edges(edges), .ev(timerEv),
		.flagByte(flagByte), .enableByte(enableByte), .nIrq(nIrq)
	);

	// Output side
	viaPortRegs i_portRegs (
		.clk(clk), .nRESET(nRESET), .req(req), .readReg(readReg),
		.portAIn(portAIn), .portBIn(portBIn), .t1Count(t1Count),
		.t1Latch(t1Latch), .t2Count(t2Count), .pb7(pb7), .flagByte(flagByte),
		.enableByte(enableByte), .ctrl(ctrl), .dataOut(dataOut),
		.portAOut(portAOut), .portAOe(portAOe), .portBOut(portBOut),
		.portBOe(portBOe)
	);

endmodule

`default_nettype wire

//--- hw/viaPortRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "via_settings.svh"

module viaPortRegs import viaPkg::*; (
	input  logic                    clk,
	input  logic                    nRESET,
	input  busReqT                  req,
	input  viaRegE                  readReg,
	input  logic [`VIA_DATA_W-1:0]  portAIn,
	input  logic [`VIA_DATA_W-1:0]  portBIn,
	input  logic [`VIA_TIMER_W-1:0] t1Count,
	input  logic [`VIA_TIMER_W-1:0] t1Latch,
	input  logic [`VIA_TIMER_W-1:0] t2Count,
	input  logic                    pb7,
	input  logic [`VIA_DATA_W-1:0]  flagByte,
	input  logic [`VIA_DATA_W-1:0]  enableByte,
	output ctrlRegsT                ctrl,
	output logic [`VIA_DATA_W-1:0]  dataOut,
	output logic [`VIA_DATA_W-1:0]  portAOut,
	output logic [`VIA_DATA_W-1:0]  portAOe,
	output logic [`VIA_DATA_W-1:0]  portBOut,
	output logic [`VIA_DATA_W-1:0]  portBOe
);

	logic [`VIA_DATA_W-1:0] ora;
	logic [`VIA_DATA_W-1:0] orb;
	logic [`VIA_DATA_W-1:0] ddra;
	logic [`VIA_DATA_W-1:0] ddrb;
	logic [`VIA_DATA_W-1:0] acr;
	logic [`VIA_DATA_W-1:0] pcr;
	logic                   wrEn;

	assign wrEn = req.valid & req.write;

	// Output registers A and B
	always_ff @(posedge clk) begin
		if (wrEn && req.regSel == regOra) begin
			ora <= req.wdata;
		end
		if (wrEn && req.regSel == regOrb) begin
			orb <= req.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ddra <= '0;
			ddrb <= '0;
			acr  <= '0;
			pcr  <= '0;
		end else if (wrEn) begin
			case (req.regSel)
				regDdra: ddra <= req.wdata;
				regDdrb: ddrb <= req.wdata;
				regAcr:  acr  <= req.wdata;
				regPcr:  pcr  <= req.wdata;
				default: ;
			endcase
		end
	end

	assign ctrl.acr = acr;
	assign ctrl.pcr = pcr;

	// ACR bit 7 hands PB7 to timer 1
	assign portAOut = ora;
	assign portAOe  = ddra;
	assign portBOut = {acr[7] ? pb7 : orb[7], orb[`VIA_DATA_W-2:0]};
	assign portBOe  = ddrb;

	always_comb begin
		case (readReg)
			// Driven value on output bits, pin level on inputs
			regOrb:  dataOut = (portBOut & ddrb) | (portBIn & ~ddrb);
			regOra:  dataOut = (ora & ddra) | (portAIn & ~ddra);
			regDdrb: dataOut = ddrb;
			regDdra: dataOut = ddra;
			regT1cL: dataOut = t1Count[`VIA_DATA_W-1:0];
			regT1cH: dataOut = t1Count[`VIA_TIMER_W-1:`VIA_DATA_W];
			regT1lL: dataOut = t1Latch[`VIA_DATA_W-1:0];
			regT1lH: dataOut = t1Latch[`VIA_TIMER_W-1:`VIA_DATA_W];
			regT2cL: dataOut = t2Count[`VIA_DATA_W-1:0];
			regT2cH: dataOut = t2Count[`VIA_TIMER_W-1:`VIA_DATA_W];
			regAcr:  dataOut = acr;
			regPcr:  dataOut = pcr;
			regIfr:  dataOut = flagByte;
			regIer:  dataOut = enableByte;
			// SR and idle
			default: dataOut = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/viaIrqFlags.sv
`timescale 1ns/1ps
`default_nettype none

`include "via_settings.svh"

module viaIrqFlags import viaPkg::*; (
	input  logic                   clk,
	input  logic                   nRESET,
	input  busReqT                 req,
	input  ctrlEdgeT               edges,
	input  timerEvT                ev,
	output logic [`VIA_DATA_W-1:0] flagByte,
	output logic [`VIA_DATA_W-1:0] enableByte,
	output logic                   nIrq
);

	// IFR bit positions; bit 2 belongs to the absent shift register
	localparam int FlagCa2 = 0;
	localparam int FlagCa1 = 1;
	localparam int FlagCb2 = 3;
	localparam int FlagCb1 = 4;
	localparam int FlagT2  = 5;
	localparam int FlagT1  = 6;

	logic [`VIA_NUM_FLAGS-1:0] flags;
	logic [`VIA_NUM_FLAGS-1:0] enables;
	logic [`VIA_NUM_FLAGS-1:0] setMask;
	logic [`VIA_NUM_FLAGS-1:0] clrMask;

	always_comb begin
		setMask = '0;
		setMask[FlagCa2] = edges.ca2;
		setMask[FlagCa1] = edges.ca1;
		setMask[FlagCb2] = edges.cb2;
		setMask[FlagCb1] = edges.cb1;
		setMask[FlagT2]  = ev.t2Underflow;
		setMask[FlagT1]  = ev.t1Underflow;

		clrMask = '0;
		if (req.valid) begin
			case (req.regSel)
				regT1cL: clrMask[FlagT1] = ~req.write;
				regT1cH: clrMask[FlagT1] = req.write;
				regT2cL: clrMask[FlagT2] = ~req.write;
				regT2cH: clrMask[FlagT2] = req.write;
				regOra: begin
					clrMask[FlagCa1] = 1'b1;
					clrMask[FlagCa2] = 1'b1;
				end
				regOrb: begin
					clrMask[FlagCb1] = 1'b1;
					clrMask[FlagCb2] = 1'b1;
				end
				// Write one to clear
				regIfr: if (req.write) clrMask = req.wdata[`VIA_NUM_FLAGS-1:0];
				default: ;
			endcase
		end
	end

	// New events win over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			flags <= '0;
		end else begin
			flags <= (flags & ~clrMask) | setMask;
		end
	end

	// Bit 7 of the written byte selects set or clear
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			enables <= '0;
		end else if (req.valid && req.write && req.regSel == regIer) begin
			if (req.wdata[`VIA_DATA_W-1]) begin
				enables <= enables | req.wdata[`VIA_NUM_FLAGS-1:0];
			end else begin
				enables <= enables & ~req.wdata[`VIA_NUM_FLAGS-1:0];
			end
		end
	end

	assign nIrq = ~|(flags & enables);
	assign flagByte = {~nIrq, flags};
	assign enableByte = {1'b1, enables};

endmodule

`default_nettype wire

//--- hw/viaTimers.sv
`timescale 1ns/1ps
`default_nettype none

`include "via_settings.svh"

module viaTimers import viaPkg::*; (
	input  logic                    clk,
	input  logic                    nRESET,
	input  logic                    clkEn,
	input  busReqT                  req,
	input  ctrlRegsT                ctrl,
	output timerEvT                 ev,
	output logic [`VIA_TIMER_W-1:0] t1Count,
	output logic [`VIA_TIMER_W-1:0] t1Latch,
	output logic [`VIA_TIMER_W-1:0] t2Count,
	output logic                    pb7
);

	logic [`VIA_DATA_W-1:0] t2LatchL;
	logic                   t1Armed;
	logic                   t2Armed;
	logic                   wrEn;
	logic                   wrT1L;
	logic                   wrT1LatH;
	logic                   wrT1H;
	logic                   wrT2L;
	logic                   wrT2H;
	logic                   t1Zero;
	logic                   t2Zero;
	timerModeE              t1Mode;

	assign t1Mode = timerModeE'(ctrl.acr[6]);

	assign wrEn     = req.valid & req.write;
	assign wrT1L    = wrEn & (req.regSel == regT1cL || req.regSel == regT1lL);
	assign wrT1LatH = wrEn & (req.regSel == regT1lH);
	assign wrT1H    = wrEn & (req.regSel == regT1cH);
	assign wrT2L    = wrEn & (req.regSel == regT2cL);
	assign wrT2H    = wrEn & (req.regSel == regT2cH);

	assign t1Zero = clkEn & (t1Count == '0);
	assign t2Zero = clkEn & (t2Count == '0);

	// A load in the same cycle hides the zero
	assign ev.t1Underflow = t1Zero & ~wrT1H & ((t1Mode == t1FreeRun) | t1Armed);
	assign ev.t2Underflow = t2Zero & ~wrT2H & t2Armed;

	// Writing the counter high byte also sets the latch high byte
	always_ff @(posedge clk) begin
		if (wrT1L) begin
			t1Latch[`VIA_DATA_W-1:0] <= req.wdata;
		end
		if (wrT1LatH || wrT1H) begin
			t1Latch[`VIA_TIMER_W-1:`VIA_DATA_W] <= req.wdata;
		end
		if (wrT2L) begin
			t2LatchL <= req.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			t1Count <= '0;
			t1Armed <= 1'b0;
		end else if (wrT1H) begin
			t1Count <= {req.wdata, t1Latch[`VIA_DATA_W-1:0]};
			t1Armed <= 1'b1;
		end else if (clkEn) begin
			if (t1Zero && t1Mode == t1FreeRun) begin
				t1Count <= t1Latch;
			end else begin
				t1Count <= t1Count - 1'b1;
			end
			if (t1Zero) begin
				t1Armed <= 1'b0;
			end
		end
	end

	// Timer 2 keeps counting down past zero without reload
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			t2Count <= '0;
			t2Armed <= 1'b0;
		end else if (wrT2H) begin
			t2Count <= {req.wdata, t2LatchL};
			t2Armed <= 1'b1;
		end else if (clkEn) begin
			t2Count <= t2Count - 1'b1;
			if (t2Zero) begin
				t2Armed <= 1'b0;
			end
		end
	end

	// Low from load; one-shot returns high, free-run toggles
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			pb7 <= 1'b1;
		end else if (wrT1H) begin
			pb7 <= 1'b0;
		end else if (ev.t1Underflow) begin
			pb7 <= (t1Mode == t1FreeRun) ? ~pb7 : 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/viaEdgeDetect.sv
`timescale 1ns/1ps
`default_nettype none

module viaEdgeDetect import viaPkg::*; (
	input  logic     clk,
	input  logic     nRESET,
	input  logic     ca1,
	input  logic     ca2,
	input  logic     cb1,
	input  logic     cb2,
	input  ctrlRegsT ctrl,
	output ctrlEdgeT edges
);

	// Lines ordered ca1, ca2, cb1, cb2 from bit 0
	logic [3:0] pins;
	logic [3:0] sync1;
	logic [3:0] sync2;
	logic [3:0] prev;
	logic [3:0] rising;
	logic [3:0] falling;
	logic [3:0] polarity;
	logic [3:0] hit;

	assign pins = {cb2, cb1, ca2, ca1};

	// PCR bits 0, 2, 4, 6; a one selects the rising edge
	assign polarity = {ctrl.pcr[6], ctrl.pcr[4], ctrl.pcr[2], ctrl.pcr[0]};

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			sync1 <= '0;
			sync2 <= '0;
			prev  <= '0;
		end else begin
			sync1 <= pins;
			sync2 <= sync1;
			prev  <= sync2;
		end
	end

	assign rising  = sync2 & ~prev;
	assign falling = ~sync2 & prev;
	assign hit = (polarity & rising) | (~polarity & falling);

	assign edges.ca1 = hit[0];
	assign edges.ca2 = hit[1];
	assign edges.cb1 = hit[2];
	assign edges.cb2 = hit[3];

endmodule

`default_nettype wire

//--- hw/viaBusDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "via_settings.svh"

module viaBusDecode import viaPkg::*; (
	input  logic                   clk,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  logic                   cs1,
	input  logic                   nCs2,
	input  logic                   rnW,
	input  logic [3:0]             rs,
	input  logic [`VIA_DATA_W-1:0] dataIn,
	output busReqT                 req,
	output viaRegE                 readReg
);

	logic   selected;
	logic   access;
	logic   wrNow;
	logic   wrPrev;
	viaRegE rawSel;
	viaRegE sel;

	// ORA without handshake behaves exactly like ORA here
	assign rawSel = viaRegE'(rs);
	assign sel = (rawSel == regOraNh) ? regOra : rawSel;

	assign selected = cs1 & ~nCs2;
	assign access = selected & clkEn;
	assign wrNow = access & ~rnW;

	// Remembers a write in the previous cycle
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			wrPrev <= 1'b0;
		end else begin
			wrPrev <= wrNow;
		end
	end

	// A write held over several enabled cycles counts once
	assign req.valid = access & ~(wrNow & wrPrev);
	assign req.write = ~rnW;
	assign req.regSel = sel;
	assign req.wdata = dataIn;

	// Idle select points at the SR address, which reads as zero
	assign readReg = (selected & rnW) ? sel : regSr;

endmodule

`default_nettype wire

//--- hw/viaPkg.sv
`default_nettype none

`include "via_settings.svh"

package viaPkg;

	// Register select, numbered as on the RS pins
	typedef enum logic [3:0] {
		regOrb   = 4'h0,
		regOra   = 4'h1,
		regDdrb  = 4'h2,
		regDdra  = 4'h3,
		regT1cL  = 4'h4,
		regT1cH  = 4'h5,
		regT1lL  = 4'h6,
		regT1lH  = 4'h7,
		regT2cL  = 4'h8,
		regT2cH  = 4'h9,
		regSr    = 4'hA,
		regAcr   = 4'hB,
		regPcr   = 4'hC,
		regIfr   = 4'hD,
		regIer   = 4'hE,
		regOraNh = 4'hF
	} viaRegE;

	// ACR bit 6
	typedef enum logic {
		t1OneShot = 1'b0,
		t1FreeRun = 1'b1
	} timerModeE;

	// One qualified bus access
	typedef struct packed {
		logic                   valid;
		logic                   write;
		viaRegE                 regSel;
		logic [`VIA_DATA_W-1:0] wdata;
	} busReqT;

	typedef struct packed {
		logic ca1;
		logic ca2;
		logic cb1;
		logic cb2;
	} ctrlEdgeT;

	typedef struct packed {
		logic t1Underflow;
		logic t2Underflow;
	} timerEvT;

	typedef struct packed {
		logic [`VIA_DATA_W-1:0] acr;
		logic [`VIA_DATA_W-1:0] pcr;
	} ctrlRegsT;

endpackage

`default_nettype wire

//--- hw/via_settings.svh
`ifndef VIA_SETTINGS_SVH
`define VIA_SETTINGS_SVH

// Host data bus and port width
`define VIA_DATA_W 8

// Timer counters and latches
`define VIA_TIMER_W 16

// Interrupt sources in IFR/IER bits 0 to 6
// Bit 7 of both registers is reserved for the summary bit
`define VIA_NUM_FLAGS 7

`endif
